//--- design/clmul_defs.svh
// ~~~~~~~~~~~~~~~~~~~~
// Carry-less multiplier widths
// Operand, half and product sizes and credit depths
// ~~~~~~~~~~~~~~~~~~~~

`ifndef CLMUL_DEFS_SVH
`define CLMUL_DEFS_SVH

// Full operand and its Karatsuba half
`define CLMUL_OP_W   192
`define CLMUL_HALF_W 96

// Full carry-less product
`define CLMUL_PROD_W 384

// Operand buffer depth, one credit per slot
`define CLMUL_IN_CREDITS 1

// Largest number of output credits the consumer may have outstanding
`define CLMUL_OUT_CREDITS 4

`endif

//--- design/clmul_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Carry-less multiplier types
// Vector types and controller states
// ~~~~~~~~~~~~~~~~~~~~

`include "clmul_defs.svh"

package clmul_pkg;

	// Full 192-bit operand
	typedef logic [`CLMUL_OP_W-1:0] operand_t;

	// One Karatsuba half
	typedef logic [`CLMUL_HALF_W-1:0] half_t;

	// Product of two halves
	typedef logic [2*`CLMUL_HALF_W-1:0] half_prod_t;

	// Full product of two operands
	typedef logic [`CLMUL_PROD_W-1:0] product_t;

	// Multiplier stage sequencing
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		COMBINE,
		HOLD
	} ctrl_state_t;

endpackage

//--- design/clmul_serial.sv
// ~~~~~~~~~~~~~~~~~~~~
// Serial carry-less multiplier
// Shift-and-XOR, one bit of x per cycle
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "clmul_defs.svh"

module clmul_serial #(
	parameter int WIDTH = `CLMUL_HALF_W
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  logic [WIDTH-1:0]   x,
	input  logic [WIDTH-1:0]   y,
	output logic [2*WIDTH-1:0] p,
	output logic               done
);

	localparam int CNT_W = $clog2(WIDTH + 1);

	// Remaining multiplier bits, LSB is the next bit to use
	logic [WIDTH-1:0]   x_sh;
	// Multiplicand aligned to the current bit position
	logic [2*WIDTH-1:0] y_sh;
	logic [2*WIDTH-1:0] acc;
	logic [CNT_W-1:0]   bit_cnt;
	logic               busy;

	// Bit counter and done pulse
	// Bit 0 is taken in the start cycle, so the last bit lands WIDTH-1 cycles later
	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			done    <= 1'b0;
			bit_cnt <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy    <= 1'b1;
				bit_cnt <= CNT_W'(1);
			end else if (busy) begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == CNT_W'(WIDTH - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// Accumulator and operand shifters
	always_ff @(posedge clk) begin
		if (start) begin
			if (x[0]) begin
				acc <= {{WIDTH{1'b0}}, y};
			end else begin
				acc <= '0;
			end
			x_sh <= x >> 1;
			y_sh <= {{WIDTH{1'b0}}, y} << 1;
		end else if (busy) begin
			if (x_sh[0]) begin
				acc <= acc ^ y_sh;
			end
			x_sh <= x_sh >> 1;
			y_sh <= y_sh << 1;
		end
	end

	// Valid while done is high and until the next start
	assign p = acc;

	// The controller must wait for done before starting again
	a_no_start_when_busy: assert property (
		@(posedge clk) disable iff (rst)
		start |-> !busy
	) else $error("clmul_serial: start while a multiply is in progress");

endmodule

//--- design/karatsuba_combine.sv
// ~~~~~~~~~~~~~~~~~~~~
// Karatsuba recombination
// Merges three partial products into the full product
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "clmul_defs.svh"

module karatsuba_combine (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  load,
	input  clmul_pkg::half_prod_t p_hi,
	input  clmul_pkg::half_prod_t p_lo,
	input  clmul_pkg::half_prod_t p_mid,
	output clmul_pkg::product_t   c,
	output logic                  c_valid
);

	// Cross term, subtraction is XOR over GF(2)
	clmul_pkg::half_prod_t mid_term;

	// Each partial product placed at its weight
	clmul_pkg::product_t hi_part;
	clmul_pkg::product_t mid_part;
	clmul_pkg::product_t lo_part;
	clmul_pkg::product_t sum;

	assign mid_term = p_mid ^ p_hi ^ p_lo;

	assign hi_part  = clmul_pkg::product_t'(p_hi) << `CLMUL_OP_W;
	assign mid_part = clmul_pkg::product_t'(mid_term) << `CLMUL_HALF_W;
	assign lo_part  = clmul_pkg::product_t'(p_lo);

	// Terms overlap, so they are XORed and not concatenated
	assign sum = hi_part ^ mid_part ^ lo_part;

	// Product register
	always_ff @(posedge clk) begin
		if (load) begin
			c <= sum;
		end
	end

	// One cycle behind load
	always_ff @(posedge clk) begin
		if (rst) begin
			c_valid <= 1'b0;
		end else begin
			c_valid <= load;
		end
	end

endmodule

//--- design/karatsuba_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~
// Karatsuba controller
// Operand buffer, multiplier sequencing, result register
// and the input and output credit handling
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "clmul_defs.svh"

module karatsuba_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  clmul_pkg::operand_t a,
	input  clmul_pkg::operand_t b,
	output logic                in_credit,
	output clmul_pkg::operand_t a_hold,
	output clmul_pkg::operand_t b_hold,
	output logic                mul_start,
	input  logic                mul_done,
	output logic                comb_load,
	input  logic                comb_valid,
	input  clmul_pkg::product_t comb_c,
	input  logic                out_credit,
	output logic                out_valid,
	output clmul_pkg::product_t c
);

	localparam int IN_CNT_W  = $clog2(`CLMUL_IN_CREDITS + 1);
	localparam int OUT_CNT_W = $clog2(`CLMUL_OUT_CREDITS + 1);

	clmul_pkg::ctrl_state_t state;

	logic                 buf_full;
	logic [IN_CNT_W-1:0]  init_left;
	logic                 init_pulse;
	logic                 res_full;
	logic                 res_free;
	logic                 res_load;
	logic [OUT_CNT_W-1:0] out_cnt;

	// Initial credits go out one per cycle once reset is released
	always_ff @(posedge clk) begin
		if (rst) begin
			init_left  <= IN_CNT_W'(`CLMUL_IN_CREDITS);
			init_pulse <= 1'b0;
		end else begin
			init_pulse <= (init_left != '0);
			if (init_left != '0) begin
				init_left <= init_left - 1'b1;
			end
		end
	end

	// The buffer slot is given back as soon as its operands enter the multipliers
	assign in_credit = init_pulse | mul_start;

	// Operand buffer, also the stable operand source for the multipliers
	always_ff @(posedge clk) begin
		if (rst) begin
			buf_full <= 1'b0;
		end else if (in_valid) begin
			buf_full <= 1'b1;
		end else if (mul_start) begin
			buf_full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			a_hold <= a;
			b_hold <= b;
		end
	end

	// Multiplier stage
	assign mul_start = (state == clmul_pkg::IDLE) && buf_full;
	assign comb_load = (state == clmul_pkg::RUN) && mul_done;

	// Result register frees up in the same cycle it is sent
	assign res_free = !res_full || out_valid;
	assign res_load = res_free &&
		(((state == clmul_pkg::COMBINE) && comb_valid) || (state == clmul_pkg::HOLD));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= clmul_pkg::IDLE;
		end else begin
			case (state)
				clmul_pkg::IDLE: begin
					if (buf_full) begin
						state <= clmul_pkg::RUN;
					end
				end
				clmul_pkg::RUN: begin
					if (mul_done) begin
						state <= clmul_pkg::COMBINE;
					end
				end
				clmul_pkg::COMBINE: begin
					// Product waits in the combiner if the result register is taken
					if (comb_valid) begin
						state <= res_load ? clmul_pkg::IDLE : clmul_pkg::HOLD;
					end
				end
				clmul_pkg::HOLD: begin
					if (res_load) begin
						state <= clmul_pkg::IDLE;
					end
				end
				default: state <= clmul_pkg::IDLE;
			endcase
		end
	end

	// Result register
	always_ff @(posedge clk) begin
		if (rst) begin
			res_full <= 1'b0;
		end else if (res_load) begin
			res_full <= 1'b1;
		end else if (out_valid) begin
			res_full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (res_load) begin
			c <= comb_c;
		end
	end

	// Output credits, a grant and a send in one cycle cancel out
	always_ff @(posedge clk) begin
		if (rst) begin
			out_cnt <= '0;
		end else if (out_credit && !out_valid) begin
			out_cnt <= out_cnt + 1'b1;
		end else if (!out_credit && out_valid) begin
			out_cnt <= out_cnt - 1'b1;
		end
	end

	assign out_valid = res_full && (out_cnt != '0);

	// Producer only sends into a free slot, or one freed this cycle
	a_no_buf_overrun: assert property (
		@(posedge clk) disable iff (rst)
		in_valid |-> (!buf_full || mul_start)
	) else $error("karatsuba_ctrl: operands sent while the buffer is full");

	// Consumer never has more credits outstanding than the counter holds
	a_out_credit_limit: assert property (
		@(posedge clk) disable iff (rst)
		(out_credit && !out_valid) |-> (out_cnt < OUT_CNT_W'(`CLMUL_OUT_CREDITS))
	) else $error("karatsuba_ctrl: output credit beyond the counter limit");

	// All three multipliers finish together while the stage is running
	a_done_in_run: assert property (
		@(posedge clk) disable iff (rst)
		mul_done |-> (state == clmul_pkg::RUN)
	) else $error("karatsuba_ctrl: multiplier done outside RUN");

endmodule

//--- design/karatsuba_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// 192-bit Karatsuba carry-less multiplier
// One Karatsuba level over three serial half multipliers
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "clmul_defs.svh"

module karatsuba_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  clmul_pkg::operand_t a,
	input  clmul_pkg::operand_t b,
	output logic                in_credit,
	input  logic                out_credit,
	output logic                out_valid,
	output clmul_pkg::product_t c
);

	clmul_pkg::operand_t   a_hold;
	clmul_pkg::operand_t   b_hold;
	logic                  mul_start;
	logic                  done_hi;
	logic                  done_lo;
	logic                  done_mid;
	logic                  comb_load;
	logic                  comb_valid;
	clmul_pkg::half_prod_t p_hi;
	clmul_pkg::half_prod_t p_lo;
	clmul_pkg::half_prod_t p_mid;
	clmul_pkg::product_t   comb_c;

	// Operand halves
	wire clmul_pkg::half_t a_hi = a_hold[`CLMUL_OP_W-1:`CLMUL_HALF_W];
	wire clmul_pkg::half_t a_lo = a_hold[`CLMUL_HALF_W-1:0];
	wire clmul_pkg::half_t b_hi = b_hold[`CLMUL_OP_W-1:`CLMUL_HALF_W];
	wire clmul_pkg::half_t b_lo = b_hold[`CLMUL_HALF_W-1:0];

	// Middle operands, sum of halves over GF(2)
	wire clmul_pkg::half_t a_mid = a_hi ^ a_lo;
	wire clmul_pkg::half_t b_mid = b_hi ^ b_lo;

	karatsuba_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.a          (a),
		.b          (b),
		.in_credit  (in_credit),
		.a_hold     (a_hold),
		.b_hold     (b_hold),
		.mul_start  (mul_start),
		.mul_done   (done_hi & done_lo & done_mid),
		.comb_load  (comb_load),
		.comb_valid (comb_valid),
		.comb_c     (comb_c),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.c          (c)
	);

	clmul_serial #(.WIDTH(`CLMUL_HALF_W)) u_mul_hi (
		.clk   (clk),
		.rst   (rst),
		.start (mul_start),
		.x     (a_hi),
		.y     (b_hi),
		.p     (p_hi),
		.done  (done_hi)
	);

	clmul_serial #(.WIDTH(`CLMUL_HALF_W)) u_mul_lo (
		.clk   (clk),
		.rst   (rst),
		.start (mul_start),
		.x     (a_lo),
		.y     (b_lo),
		.p     (p_lo),
		.done  (done_lo)
	);

	clmul_serial #(.WIDTH(`CLMUL_HALF_W)) u_mul_mid (
		.clk   (clk),
		.rst   (rst),
		.start (mul_start),
		.x     (a_mid),
		.y     (b_mid),
		.p     (p_mid),
		.done  (done_mid)
	);

	karatsuba_combine u_combine (
		.clk     (clk),
		.rst     (rst),
		.load    (comb_load),
		.p_hi    (p_hi),
		.p_lo    (p_lo),
		.p_mid   (p_mid),
		.c       (comb_c),
		.c_valid (comb_valid)
	);

endmodule

//--- karatsuba_top.f
+incdir+design
design/clmul_pkg.sv
design/clmul_serial.sv
design/karatsuba_combine.sv
design/karatsuba_ctrl.sv
design/karatsuba_top.sv
sim/tb_clock.sv
sim/karatsuba_checker.sv
sim/karatsuba_tb.sv

//--- sim/karatsuba_checker.sv
// ~~~~~~~~~~~~~~~~~~~~
// Karatsuba multiplier checker
// Expected products from a reference multiply, credit rules
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "clmul_defs.svh"

module karatsuba_checker (
	input  logic                clk,
	input  logic                rst,
	input  logic                in_valid,
	input  clmul_pkg::operand_t a,
	input  clmul_pkg::operand_t b,
	input  logic                in_credit,
	input  logic                out_credit,
	input  logic                out_valid,
	input  clmul_pkg::product_t c,
	output int                  mismatch_count,
	output int                  error_count,
	output int                  input_count,
	output int                  result_count
);

	clmul_pkg::product_t exp_q[$];
	clmul_pkg::product_t expected;
	int                  in_cred;
	int                  out_cred;
	logic                ref_bad;

	// Plain shift-and-XOR over the full operand width
	function automatic clmul_pkg::product_t clmul_ref(
		input clmul_pkg::operand_t x,
		input clmul_pkg::operand_t y
	);
		clmul_pkg::product_t r;
		r = '0;
		for (int i = 0; i < `CLMUL_OP_W; i++) begin
			if (x[i]) begin
				r = r ^ (clmul_pkg::product_t'(y) << i);
			end
		end
		return r;
	endfunction

	// Top bit times top bit lands at bit 382
	initial begin
		ref_bad = 1'b0;
		if (clmul_ref(clmul_pkg::operand_t'(1) << 191, clmul_pkg::operand_t'(1) << 191)
				!= (clmul_pkg::product_t'(1) << 382)) begin
			$display("ERROR: reference multiply does not place the top product bit at 382");
			ref_bad = 1'b1;
		end
	end

	always @(posedge clk) begin
		if (rst) begin
			exp_q.delete();
			in_cred        = 0;
			out_cred       = 0;
			mismatch_count = 0;
			error_count    = ref_bad ? 1 : 0;
			input_count    = 0;
			result_count   = 0;
		end else begin
			// Input side, the buffer has only so many slots
			if (in_credit) begin
				in_cred = in_cred + 1;
			end
			if (in_cred > `CLMUL_IN_CREDITS) begin
				$display("ERROR at %0t: input credit returned while the buffer was full", $time);
				error_count = error_count + 1;
				in_cred     = `CLMUL_IN_CREDITS;
			end
			if (in_valid) begin
				if (in_cred == 0) begin
					$display("ERROR at %0t: operands sent without an input credit", $time);
					error_count = error_count + 1;
				end else begin
					in_cred = in_cred - 1;
				end
				exp_q.push_back(clmul_ref(a, b));
				input_count = input_count + 1;
			end

			// Output side, results in order and within the granted credits
			if (out_valid) begin
				if (out_cred == 0) begin
					$display("ERROR at %0t: result sent beyond the credits granted", $time);
					error_count = error_count + 1;
				end else begin
					out_cred = out_cred - 1;
				end
				if (exp_q.size() == 0) begin
					$display("ERROR at %0t: result arrived with no input waiting for it", $time);
					error_count = error_count + 1;
				end else begin
					expected = exp_q.pop_front();
					if (c !== expected) begin
						$display("MISMATCH at %0t: result %0d expected %h got %h",
							$time, result_count, expected, c);
						mismatch_count = mismatch_count + 1;
					end
				end
				result_count = result_count + 1;
			end
			if (out_credit) begin
				out_cred = out_cred + 1;
			end
		end
	end

endmodule

//--- sim/karatsuba_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Karatsuba multiplier testbench
// Credit producer and consumer, directed and random operands
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "clmul_defs.svh"

module karatsuba_tb;

	localparam int NUM_DIRECTED   = 6;
	localparam int NUM_RANDOM     = 40;
	localparam int NUM_STALL      = 12;
	localparam int NUM_BURST      = 10;
	localparam int NUM_OPS        = NUM_DIRECTED + NUM_RANDOM + NUM_STALL + NUM_BURST;
	localparam int TIMEOUT_CYCLES = NUM_OPS * 110 + 500;

	logic                clk;
	logic                rst;
	logic                in_valid;
	clmul_pkg::operand_t a;
	clmul_pkg::operand_t b;
	logic                in_credit;
	logic                out_credit;
	logic                out_valid;
	clmul_pkg::product_t c;

	int mismatch_count;
	int error_count;
	int input_count;
	int result_count;

	clmul_pkg::operand_t pend_a[$];
	clmul_pkg::operand_t pend_b[$];
	int                  seed;
	int                  tb_errors;
	int                  cycle_count;
	int                  prod_credits;
	int                  sent_count;
	int                  results_seen;
	int                  outstanding;
	int                  credit_mode;
	int                  credit_tick;
	int                  peak;
	logic                want_credit;
	clmul_pkg::operand_t r1;
	clmul_pkg::operand_t r2;

	tb_clock u_clock (
		.clk (clk)
	);

	karatsuba_top u_dut (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.a          (a),
		.b          (b),
		.in_credit  (in_credit),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.c          (c)
	);

	karatsuba_checker u_checker (
		.clk            (clk),
		.rst            (rst),
		.in_valid       (in_valid),
		.a              (a),
		.b              (b),
		.in_credit      (in_credit),
		.out_credit     (out_credit),
		.out_valid      (out_valid),
		.c              (c),
		.mismatch_count (mismatch_count),
		.error_count    (error_count),
		.input_count    (input_count),
		.result_count   (result_count)
	);

	function automatic clmul_pkg::operand_t random_operand();
		clmul_pkg::operand_t v;
		for (int i = 0; i < `CLMUL_OP_W / 32; i++) begin
			v[i*32 +: 32] = $random(seed);
		end
		return v;
	endfunction

	task automatic queue_op(input clmul_pkg::operand_t x, input clmul_pkg::operand_t y);
		pend_a.push_back(x);
		pend_b.push_back(y);
	endtask

	// Waits until every queued operation has come back, tracking the peak in flight
	task automatic drain(output int max_in_flight);
		max_in_flight = 0;
		while (pend_a.size() != 0 || results_seen != sent_count) begin
			@(posedge clk);
			if (sent_count - results_seen > max_in_flight) begin
				max_in_flight = sent_count - results_seen;
			end
		end
		repeat (20) @(posedge clk);
	endtask

	// Producer sends only while it holds a credit
	always @(negedge clk) begin
		if (rst) begin
			in_valid     = 1'b0;
			prod_credits = 0;
		end else begin
			if (in_credit) begin
				prod_credits = prod_credits + 1;
			end
			if (prod_credits > 0 && pend_a.size() != 0) begin
				a            = pend_a.pop_front();
				b            = pend_b.pop_front();
				in_valid     = 1'b1;
				prod_credits = prod_credits - 1;
				sent_count   = sent_count + 1;
			end else begin
				in_valid = 1'b0;
			end
		end
	end

	// Consumer keeps at most CLMUL_OUT_CREDITS credits outstanding
	always @(negedge clk) begin
		if (rst) begin
			out_credit  = 1'b0;
			outstanding = 0;
		end else begin
			if (out_valid) begin
				outstanding  = outstanding - 1;
				results_seen = results_seen + 1;
			end
			credit_tick = credit_tick + 1;
			case (credit_mode)
				1:       want_credit = 1'b1;
				2:       want_credit = (credit_tick % 37 == 0);
				default: want_credit = 1'b0;
			endcase
			if (want_credit && outstanding < `CLMUL_OUT_CREDITS) begin
				out_credit  = 1'b1;
				outstanding = outstanding + 1;
			end else begin
				out_credit = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("ERROR: timeout after %0d cycles with %0d of %0d results received",
				cycle_count, results_seen, sent_count);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		rst          = 1'b1;
		in_valid     = 1'b0;
		a            = '0;
		b            = '0;
		out_credit   = 1'b0;
		seed         = 32'h8a62ac07;
		tb_errors    = 0;
		cycle_count  = 0;
		sent_count   = 0;
		results_seen = 0;
		credit_mode  = 1;
		credit_tick  = 0;
		repeat (3) @(negedge clk);
		rst = 1'b0;

		// Initial credit in the first cycle after reset, nothing out yet
		@(negedge clk);
		if (!in_credit) begin
			$display("ERROR at %0t: no input credit in the first cycle after reset", $time);
			tb_errors = tb_errors + 1;
		end
		repeat (20) @(posedge clk);

		// Directed operands with sparse output credits
		credit_mode = 2;
		r1 = random_operand();
		r2 = random_operand();
		queue_op('0, r1);
		queue_op(clmul_pkg::operand_t'(1), r2);
		queue_op('1, '1);
		queue_op(clmul_pkg::operand_t'(1) << 191, clmul_pkg::operand_t'(1) << 191);
		queue_op({96'b0, r1[95:0]}, {r2[191:96], 96'b0});
		queue_op(r2, clmul_pkg::operand_t'(1));
		drain(peak);

		// Random operands, continuous credits
		credit_mode = 1;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			r1 = random_operand();
			r2 = random_operand();
			queue_op(r1, r2);
		end
		drain(peak);

		// Back-pressure, credits withheld until the pipeline fills
		credit_mode = 0;
		for (int i = 0; i < NUM_STALL; i++) begin
			r1 = random_operand();
			r2 = random_operand();
			queue_op(r1, r2);
		end
		while (outstanding != 0) begin
			@(posedge clk);
		end
		repeat (300) @(posedge clk);
		// Buffer, multiplier stage and result register all hold one
		if (sent_count - results_seen != 3) begin
			$display("ERROR at %0t: %0d operations in flight under back-pressure, expected 3",
				$time, sent_count - results_seen);
			tb_errors = tb_errors + 1;
		end
		repeat (20) begin
			@(negedge clk);
			if (in_credit) begin
				$display("ERROR at %0t: input credit returned while the pipeline was full",
					$time);
				tb_errors = tb_errors + 1;
			end
		end
		credit_mode = 1;
		drain(peak);

		// Back-to-back operations
		for (int i = 0; i < NUM_BURST; i++) begin
			r1 = random_operand();
			r2 = random_operand();
			queue_op(r1, r2);
		end
		drain(peak);
		if (peak < 2) begin
			$display("ERROR: back-to-back inputs never had more than %0d operation in flight",
				peak);
			tb_errors = tb_errors + 1;
		end

		@(negedge clk);
		if (input_count != NUM_OPS || result_count != NUM_OPS) begin
			$display("ERROR: %0d inputs and %0d results seen, expected %0d of each",
				input_count, result_count, NUM_OPS);
			tb_errors = tb_errors + 1;
		end
		$display("Results %0d, mismatches %0d, protocol errors %0d, testbench errors %0d",
			result_count, mismatch_count, error_count, tb_errors);
		if (mismatch_count == 0 && error_count == 0 && tb_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- sim/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench clock
// Free-running 4 ns clock
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	// Half period of 2 ns
	always #2 clk = ~clk;

endmodule
